// ==== Makefile ====
# Verilator build and run for the move legality unit

VERILATOR ?= verilator
TOP       ?= tb_tetris_move
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/tetris_pkg.sv ====
// ####################
// Tetris move checker shared types,
// piece shapes and SRS wall-kick tables
// ####################

package tetris_pkg;

    localparam int PLAYFIELD_ROWS = 20;
    localparam int PLAYFIELD_COLS = 10;
    localparam int COORD_W        = 5;
    localparam int KICK_TESTS     = 5;

    typedef enum logic [3:0] {
        BLANK  = 4'd0,
        TILE_I = 4'd1,
        TILE_O = 4'd2,
        TILE_T = 4'd3,
        TILE_S = 4'd4,
        TILE_Z = 4'd5,
        TILE_J = 4'd6,
        TILE_L = 4'd7
    } tile_t;

    typedef enum logic [2:0] {
        PIECE_I, PIECE_O, PIECE_T, PIECE_S, PIECE_Z, PIECE_J, PIECE_L
    } piece_t;

    // Clockwise rotation adds one
    typedef enum logic [1:0] {
        ORIENT_0, ORIENT_R, ORIENT_2, ORIENT_L
    } orient_t;

    typedef enum logic [2:0] {
        ACT_LEFT, ACT_RIGHT, ACT_DROP, ACT_CW, ACT_CCW
    } action_t;

    typedef tile_t [PLAYFIELD_ROWS-1:0][PLAYFIELD_COLS-1:0] playfield_t;

    typedef struct packed {
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
        tile_t              tile;
    } cell_write_t;

    typedef struct packed {
        piece_t             piece;
        orient_t            orient;
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
        action_t            action;
    } move_query_t;

    typedef struct packed {
        logic               valid;
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
        orient_t            orient;
        logic [2:0]         kick_idx;
    } move_result_t;

    // One cell of a piece inside its 4x4 box
    typedef struct packed {
        logic [1:0] row;
        logic [1:0] col;
    } cell_ofs_t;

    typedef cell_ofs_t [3:0] shape_t;

    // Each hex digit is one cell as {row, col}, cell 0 in the low digit
    localparam shape_t SHAPE_TABLE [7][4] = '{
        '{16'h4567, 16'h26AE, 16'h89AB, 16'h159D},  // I
        '{16'h1256, 16'h1256, 16'h1256, 16'h1256},  // O
        '{16'h1456, 16'h1569, 16'h4569, 16'h1459},  // T
        '{16'h1245, 16'h156A, 16'h5689, 16'h0459},  // S
        '{16'h0156, 16'h2569, 16'h459A, 16'h1458},  // Z
        '{16'h0456, 16'h1259, 16'h456A, 16'h1589},  // J
        '{16'h2456, 16'h159A, 16'h4568, 16'h0159}   // L
    };

    // Negative row moves the piece up
    typedef struct packed {
        logic signed [2:0] row;
        logic signed [2:0] col;
    } kick_t;

    function automatic kick_t kick_of(int r, int c);
        kick_t k;
        k.row = 3'(r);
        k.col = 3'(c);
        return k;
    endfunction

    // Indexed by start orientation, direction (0 cw, 1 ccw) and candidate
    localparam kick_t KICK_JLSTZ [4][2][KICK_TESTS] = '{
        '{'{kick_of(0, 0), kick_of(0, -1), kick_of(-1, -1), kick_of(2, 0), kick_of(2, -1)},
          '{kick_of(0, 0), kick_of(0, 1), kick_of(-1, 1), kick_of(2, 0), kick_of(2, 1)}},
        '{'{kick_of(0, 0), kick_of(0, 1), kick_of(1, 1), kick_of(-2, 0), kick_of(-2, 1)},
          '{kick_of(0, 0), kick_of(0, 1), kick_of(1, 1), kick_of(-2, 0), kick_of(-2, 1)}},
        '{'{kick_of(0, 0), kick_of(0, 1), kick_of(-1, 1), kick_of(2, 0), kick_of(2, 1)},
          '{kick_of(0, 0), kick_of(0, -1), kick_of(-1, -1), kick_of(2, 0), kick_of(2, -1)}},
        '{'{kick_of(0, 0), kick_of(0, -1), kick_of(1, -1), kick_of(-2, 0), kick_of(-2, -1)},
          '{kick_of(0, 0), kick_of(0, -1), kick_of(1, -1), kick_of(-2, 0), kick_of(-2, -1)}}
    };

    localparam kick_t KICK_I [4][2][KICK_TESTS] = '{
        '{'{kick_of(0, 0), kick_of(0, -2), kick_of(0, 1), kick_of(1, -2), kick_of(-2, 1)},
          '{kick_of(0, 0), kick_of(0, -1), kick_of(0, 2), kick_of(-2, -1), kick_of(1, 2)}},
        '{'{kick_of(0, 0), kick_of(0, -1), kick_of(0, 2), kick_of(-2, -1), kick_of(1, 2)},
          '{kick_of(0, 0), kick_of(0, 2), kick_of(0, -1), kick_of(-1, 2), kick_of(2, -1)}},
        '{'{kick_of(0, 0), kick_of(0, 2), kick_of(0, -1), kick_of(-1, 2), kick_of(2, -1)},
          '{kick_of(0, 0), kick_of(0, 1), kick_of(0, -2), kick_of(2, 1), kick_of(-1, -2)}},
        '{'{kick_of(0, 0), kick_of(0, 1), kick_of(0, -2), kick_of(2, 1), kick_of(-1, -2)},
          '{kick_of(0, 0), kick_of(0, -2), kick_of(0, 1), kick_of(1, -2), kick_of(-2, 1)}}
    };

endpackage

// ==== hw/move_check/move_checker.sv ====
// ####################
// Move legality checker, tests one
// wall-kick candidate per clock
// ####################

`timescale 1ns/1ps

module move_checker (
    input  logic                     clk,
    input  logic                     rst_l,
    input  tetris_pkg::move_query_t  query,
    input  logic                     req,
    input  tetris_pkg::playfield_t   field,
    output logic                     ack,
    output tetris_pkg::move_result_t result
);

    import tetris_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        TEST,
        DONE
    } state_t;

    state_t             state;
    move_query_t        q;
    logic [2:0]         cand;

    logic [COORD_W-1:0] base_row;
    logic [COORD_W-1:0] base_col;
    orient_t            base_orient;
    logic               is_rot;
    logic               dir;
    kick_t              kick;
    logic [COORD_W-1:0] cand_row;
    logic [COORD_W-1:0] cand_col;
    logic [COORD_W-1:0] cell_row [4];
    logic [COORD_W-1:0] cell_col [4];
    logic               fit;
    logic               last_cand;

    // Target before any kick
    always_comb begin
        base_row    = q.row;
        base_col    = q.col;
        base_orient = q.orient;
        case (q.action)
            ACT_LEFT:  base_col    = q.col - 1'b1;
            ACT_RIGHT: base_col    = q.col + 1'b1;
            ACT_DROP:  base_row    = q.row + 1'b1;
            ACT_CW:    base_orient = orient_t'(q.orient + 2'd1);
            ACT_CCW:   base_orient = orient_t'(q.orient - 2'd1);
            default: ;
        endcase
    end

    assign is_rot = (q.action == ACT_CW) || (q.action == ACT_CCW);
    assign dir    = (q.action == ACT_CCW);

    always_comb begin
        if (!is_rot) begin
            kick = '0;
        end else if (q.piece == PIECE_I) begin
            kick = KICK_I[q.orient][dir][cand];
        end else begin
            kick = KICK_JLSTZ[q.orient][dir][cand];                // O shares JLSTZ
        end
    end

    // Signed offsets sign-extend, then wrap like the shape offsets
    assign cand_row = base_row + COORD_W'(kick.row);
    assign cand_col = base_col + COORD_W'(kick.col);

    piece_shape u_shape (
        .piece    (q.piece),
        .orient   (base_orient),
        .row      (cand_row),
        .col      (cand_col),
        .cell_row (cell_row),
        .cell_col (cell_col)
    );

    always_comb begin
        fit = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (cell_row[i] >= PLAYFIELD_ROWS || cell_col[i] >= PLAYFIELD_COLS) begin
                fit = 1'b0;
            end else if (field[cell_row[i]][cell_col[i]] != BLANK) begin
                fit = 1'b0;
            end
        end
    end

    assign last_cand = !is_rot || (cand == 3'(KICK_TESTS - 1));

    // Query held for the whole test sequence
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            q <= query;
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state  <= IDLE;
            cand   <= '0;
            result <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= TEST;
                        cand  <= '0;
                    end
                end
                TEST: begin
                    if (fit || last_cand) begin
                        state  <= DONE;
                        result <= '{valid:    fit,
                                    row:      fit ? cand_row : q.row,
                                    col:      fit ? cand_col : q.col,
                                    orient:   fit ? base_orient : q.orient,
                                    kick_idx: fit ? cand : 3'd0};
                    end else begin
                        cand <= cand + 3'd1;                     // Next kick
                    end
                end
                DONE: begin
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign ack = (state == DONE);

endmodule

// ==== hw/piece_shape.sv ====
// ####################
// Piece shape expander, gives the four
// playfield cells of a placed piece
// ####################

`timescale 1ns/1ps

module piece_shape (
    input  tetris_pkg::piece_t             piece,
    input  tetris_pkg::orient_t            orient,
    input  logic [tetris_pkg::COORD_W-1:0] row,
    input  logic [tetris_pkg::COORD_W-1:0] col,
    output logic [tetris_pkg::COORD_W-1:0] cell_row [4],
    output logic [tetris_pkg::COORD_W-1:0] cell_col [4]
);

    import tetris_pkg::*;

    shape_t shape;

    assign shape = SHAPE_TABLE[piece][orient];

    // Offsets wrap modulo 32, so a cell past the edge reads as outside
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            cell_row[i] = row + COORD_W'(shape[i].row);
            cell_col[i] = col + COORD_W'(shape[i].col);
        end
    end

endmodule

// ==== hw/playfield_regs.sv ====
// ####################
// Locked playfield registers
// ####################

`timescale 1ns/1ps

module playfield_regs (
    input  logic                    clk,
    input  logic                    rst_l,
    input  tetris_pkg::cell_write_t wr,
    input  logic                    wr_en,
    input  logic                    clr,
    output tetris_pkg::playfield_t  field
);

    import tetris_pkg::*;

    // Per-cell decode; a write off the field matches no cell
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
                for (int c = 0; c < PLAYFIELD_COLS; c++) begin
                    field[r][c] <= BLANK;
                end
            end
        end else begin
            for (int r = 0; r < PLAYFIELD_ROWS; r++) begin
                for (int c = 0; c < PLAYFIELD_COLS; c++) begin
                    if (clr) begin
                        field[r][c] <= BLANK;                    // Clear wins
                    end else if (wr_en && wr.row == COORD_W'(r) &&
                                 wr.col == COORD_W'(c)) begin
                        field[r][c] <= wr.tile;
                    end
                end
            end
        end
    end

endmodule

// ==== hw/tetris_move_top.sv ====
// ####################
// Move legality unit top, playfield
// registers beside the move checker
// ####################

`timescale 1ns/1ps

module tetris_move_top (
    input  logic                     clk,
    input  logic                     rst_l,
    input  tetris_pkg::move_query_t  query,
    input  logic                     req,
    output logic                     ack,
    output tetris_pkg::move_result_t result,
    input  tetris_pkg::cell_write_t  wr,
    input  logic                     wr_en,
    input  logic                     clr
);

    import tetris_pkg::*;

    playfield_t field;                                           // Locked cells

    playfield_regs u_playfield (
        .clk   (clk),
        .rst_l (rst_l),
        .wr    (wr),
        .wr_en (wr_en),
        .clr   (clr),
        .field (field)
    );

    move_checker u_checker (
        .clk    (clk),
        .rst_l  (rst_l),
        .query  (query),
        .req    (req),
        .field  (field),
        .ack    (ack),
        .result (result)
    );

endmodule

// ==== sim.f ====
common/tetris_pkg.sv
hw/piece_shape.sv
hw/playfield_regs.sv
hw/move_check/move_checker.sv
hw/tetris_move_top.sv
verif/move_checker_checker.sv
verif/tb_tetris_move.sv

// ==== verif/move_checker_checker.sv ====
// ####################
// Query handshake assertions, bound
// into the move checker
// ####################

`timescale 1ns/1ps

module move_checker_checker (
    input logic                     clk,
    input logic                     rst_l,
    input logic                     req,
    input logic                     ack,
    input tetris_pkg::move_result_t result
);

    int assert_fails = 0;                                        // Failed assertion count

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_l)
        $rose(ack) |-> req)
        else begin
            assert_fails++;
            $error("ack rose while req was low");
        end

    result_held: assert property (@(posedge clk) disable iff (!rst_l)
        ack && $past(ack) |-> $stable(result))
        else begin
            assert_fails++;
            $error("result changed while ack was high");
        end

    // Up to five candidates after the latch edge plus one sampling edge
    ack_latency: assert property (@(posedge clk) disable iff (!rst_l)
        $rose(req) && !ack |-> ##[2:6] ack)
        else begin
            assert_fails++;
            $error("ack did not rise within five candidates of the latch");
        end

    ack_release: assert property (@(posedge clk) disable iff (!rst_l)
        ack && !req |=> !ack)
        else begin
            assert_fails++;
            $error("ack stayed high after req was sampled low");
        end

endmodule

bind move_checker move_checker_checker u_mc_chk (
    .clk    (clk),
    .rst_l  (rst_l),
    .req    (req),
    .ack    (ack),
    .result (result)
);

// ==== verif/tb_tetris_move.sv ====
// ####################
// Testbench for the move legality unit,
// directed, random and back-pressure queries
// ####################

`timescale 1ns/1ps

module tb_tetris_move;

    import tetris_pkg::*;

    localparam int MAX_QUERIES = 350;
    localparam int MAX_WRITES  = 1100;
    localparam int CYCLE_LIMIT = 10 * MAX_QUERIES + 2 * MAX_WRITES + 400;

    logic         clk;
    logic         rst_l;
    move_query_t  query;
    logic         req;
    logic         ack;
    move_result_t result;
    cell_write_t  wr;
    logic         wr_en;
    logic         clr;

    playfield_t   model;                                         // Reference field
    move_result_t exp_q [$];
    logic [31:0]  seed = 32'h95f2;
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    logic         ack_prev = 1'b0;

    tetris_move_top DUT (
        .clk    (clk),
        .rst_l  (rst_l),
        .query  (query),
        .req    (req),
        .ack    (ack),
        .result (result),
        .wr     (wr),
        .wr_en  (wr_en),
        .clr    (clr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // LCG step giving a value in 0..n-1
    function automatic int rand_below(int n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return int'((seed >> 8) % 32'(n));
    endfunction

    function automatic move_query_t make_query(piece_t p, orient_t o, int row, int col,
                                               action_t a);
        move_query_t q;
        q.piece  = p;
        q.orient = o;
        q.row    = COORD_W'(row);
        q.col    = COORD_W'(col);
        q.action = a;
        return q;
    endfunction

    // First candidate whose four cells are on the field and blank
    function automatic move_result_t expected_move(playfield_t f, move_query_t q);
        move_result_t r;
        int           base_row;
        int           base_col;
        int           row_c;
        int           col_c;
        int           cr;
        int           cc;
        int           tries;
        int           dir;
        orient_t      tgt;
        kick_t        k;
        shape_t       shp;
        logic         ok;
        r.valid    = 1'b0;
        r.row      = q.row;
        r.col      = q.col;
        r.orient   = q.orient;
        r.kick_idx = 3'd0;
        base_row   = int'(q.row);
        base_col   = int'(q.col);
        tgt        = q.orient;
        tries      = 1;
        dir        = 0;
        case (q.action)
            ACT_LEFT:  base_col = base_col - 1;
            ACT_RIGHT: base_col = base_col + 1;
            ACT_DROP:  base_row = base_row + 1;
            ACT_CW: begin
                tgt   = orient_t'((int'(q.orient) + 1) & 3);
                tries = KICK_TESTS;
            end
            ACT_CCW: begin
                tgt   = orient_t'((int'(q.orient) + 3) & 3);
                tries = KICK_TESTS;
                dir   = 1;
            end
            default: ;
        endcase
        shp = SHAPE_TABLE[q.piece][tgt];
        for (int i = 0; i < tries; i++) begin
            if (tries == 1) begin
                k = '0;
            end else if (q.piece == PIECE_I) begin
                k = KICK_I[q.orient][dir][i];
            end else begin
                k = KICK_JLSTZ[q.orient][dir][i];
            end
            row_c = (base_row + int'(k.row)) & 31;                 // 5-bit wrap
            col_c = (base_col + int'(k.col)) & 31;
            ok    = 1'b1;
            for (int j = 0; j < 4; j++) begin
                cr = (row_c + int'(shp[j].row)) & 31;
                cc = (col_c + int'(shp[j].col)) & 31;
                if (cr >= PLAYFIELD_ROWS || cc >= PLAYFIELD_COLS) begin
                    ok = 1'b0;
                end else if (f[cr][cc] != BLANK) begin
                    ok = 1'b0;
                end
            end
            if (ok) begin
                r.valid    = 1'b1;
                r.row      = COORD_W'(row_c);
                r.col      = COORD_W'(col_c);
                r.orient   = tgt;
                r.kick_idx = 3'(i);
                return r;
            end
        end
        return r;
    endfunction

    task automatic compare_result(string name, move_result_t exp, move_result_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic compare_ack(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR t=%0t %s exp=%b act=%b", $time, name, exp, act);
        end
    endtask

    task automatic write_cell(int row, int col, tile_t tile);
        @(posedge clk);
        wr.row   <= COORD_W'(row);
        wr.col   <= COORD_W'(col);
        wr.tile  <= tile;
        wr_en    <= 1'b1;
        @(posedge clk);
        wr_en    <= 1'b0;
        if (row < PLAYFIELD_ROWS && col < PLAYFIELD_COLS) begin
            model[row][col] = tile;                              // Off-field writes ignored
        end
    endtask

    task automatic clear_field();
        @(posedge clk);
        clr <= 1'b1;
        @(posedge clk);
        clr <= 1'b0;
        model = '0;
    endtask

    task automatic run_query(move_query_t q, int hold);
        move_result_t held;
        exp_q.push_back(expected_move(model, q));
        @(posedge clk);
        query <= q;
        req   <= 1'b1;
        @(posedge clk);
        while (!ack) @(posedge clk);
        held = result;
        repeat (hold) begin
            @(posedge clk);
            compare_ack("ack", 1'b1, ack);
            compare_result("result held", held, result);
        end
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
    endtask

    // Compare each answer as ack rises
    always @(posedge clk) begin
        if (ack && !ack_prev) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ack rose with no query outstanding at t=%0t", $time);
            end else begin
                compare_result("result", exp_q.pop_front(), result);
            end
        end
        ack_prev <= ack;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the query handshake hung", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int sel;
        int nwr;
        int assert_errs;
        rst_l = 1'b0;
        req   = 1'b0;
        query = '0;
        wr    = '0;
        wr_en = 1'b0;
        clr   = 1'b0;
        model = '0;
        repeat (2) @(posedge clk);
        rst_l <= 1'b1;
        @(posedge clk);
        compare_ack("ack", 1'b0, ack);
        compare_result("result", '0, result);

        // T in mid-field on the empty field
        for (int a = 0; a < 5; a++) begin
            run_query(make_query(PIECE_T, ORIENT_0, 8, 4, action_t'(a)), 0);
        end

        // Walls and floor
        run_query(make_query(PIECE_T, ORIENT_0, 8, 0, ACT_LEFT), 0);
        run_query(make_query(PIECE_T, ORIENT_0, 8, 7, ACT_RIGHT), 0);
        run_query(make_query(PIECE_T, ORIENT_0, 18, 4, ACT_DROP), 0);
        run_query(make_query(PIECE_I, ORIENT_R, 16, 7, ACT_DROP), 0);

        // Locked cells beside and below
        write_cell(9, 3, TILE_S);
        write_cell(9, 7, TILE_L);
        write_cell(10, 5, TILE_O);
        for (int a = 0; a < 3; a++) begin
            run_query(make_query(PIECE_T, ORIENT_0, 8, 4, action_t'(a)), 0);
        end
        clear_field();
        for (int a = 0; a < 3; a++) begin
            run_query(make_query(PIECE_T, ORIENT_0, 8, 4, action_t'(a)), 0);
        end

        // Wall kicks
        run_query(make_query(PIECE_J, ORIENT_R, 5, 31, ACT_CW), 0);
        run_query(make_query(PIECE_I, ORIENT_R, 5, 7, ACT_CW), 0);
        run_query(make_query(PIECE_I, ORIENT_L, 5, 31, ACT_CCW), 0);
        write_cell(10, 5, TILE_T);
        write_cell(10, 4, TILE_T);
        run_query(make_query(PIECE_J, ORIENT_0, 10, 4, ACT_CW), 0);
        clear_field();
        for (int r = 6; r < 15; r++) begin
            for (int c = 0; c < PLAYFIELD_COLS; c++) begin
                if (!((r == 8 && c == 5) || (r == 9 && c >= 4 && c <= 6))) begin
                    write_cell(r, c, TILE_Z);
                end
            end
        end
        run_query(make_query(PIECE_T, ORIENT_0, 8, 4, ACT_CW), 0);
        run_query(make_query(PIECE_T, ORIENT_0, 8, 4, ACT_CCW), 0);
        clear_field();

        // Random queries with writes and clears between them
        for (int n = 0; n < 300; n++) begin
            sel = rand_below(16);
            if (sel == 0) begin
                clear_field();
            end else begin
                nwr = rand_below(4);
                for (int w = 0; w < nwr; w++) begin
                    write_cell(rand_below(21), rand_below(11), tile_t'(rand_below(8)));
                end
            end
            run_query(make_query(piece_t'(rand_below(7)), orient_t'(rand_below(4)),
                                 rand_below(20), rand_below(10),
                                 action_t'(rand_below(5))), 0);
        end

        // Back-pressure with req held past ack
        for (int n = 0; n < 10; n++) begin
            run_query(make_query(piece_t'(rand_below(7)), orient_t'(rand_below(4)),
                                 rand_below(20), rand_below(10),
                                 action_t'(rand_below(5))), rand_below(8) + 1);
        end

        repeat (2) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results were never compared", exp_q.size());
        end
        assert_errs = DUT.u_checker.u_mc_chk.assert_fails;
        $display("Checks: %0d, compare errors: %0d, assertion failures: %0d",
                 checks, errors, assert_errs);
        if (errors == 0 && assert_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
